/* build.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_operand_sel.sv
design/lsu_store_pack.sv
design/lsu_load_align.sv
design/lsu_ctrl.sv
design/load_store_unit.sv
dv/lsu_tb.sv

/* design/load_store_unit.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module load_store_unit
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  lsu_op_e               op,
    input  addr_t                 imm,
    input  gpr_idx_t              reg_a,
    input  gpr_idx_t              reg_b,
    input  word_t                 gpr_rdata [`LSU_GPR_N],
    output logic                  dn,
    output logic [`LSU_GPR_N-1:0] gpr_we,
    output word_t                 gpr_wdata,
    // Memory request channel.
    output logic                  mem_tx_rp,
    output addr_t                 mem_tx_addr,
    output logic                  mem_tx_wr,
    output mask_t                 mem_tx_wmsk,
    output line_t                 mem_tx_data,
    input  logic                  mem_tx_ra,
    // Memory reply channel.
    input  logic                  mem_rx_rp,
    input  addr_t                 mem_rx_addr,
    input  line_t                 mem_rx_data,
    output logic                  mem_rx_ra
);

    addr_t    lo_line;
    addr_t    hi_line;
    off_t     offset;
    logic     split;
    gpr_idx_t dest;
    word_t    store_word;
    line_t    wr_data;
    mask_t    wr_mask;
    logic     hi_piece;
    logic     lo_take;
    logic     final_take;

    // Operand decode and line split.
    lsu_operand_sel i_operand_sel (
        .op         (op),
        .imm        (imm),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .gpr_rdata  (gpr_rdata),
        .lo_line    (lo_line),
        .hi_line    (hi_line),
        .offset     (offset),
        .split      (split),
        .dest       (dest),
        .store_word (store_word)
    );

    // Store data placement.
    lsu_store_pack i_store_pack (
        .store_word (store_word),
        .offset     (offset),
        .split      (split),
        .hi_piece   (hi_piece),
        .wr_data    (wr_data),
        .wr_mask    (wr_mask)
    );

    // Load word assembly.
    lsu_load_align i_load_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (mem_rx_data),
        .offset     (offset),
        .split      (split),
        .lo_take    (lo_take),
        .final_take (final_take),
        .load_word  (gpr_wdata)
    );

    // Sequencer and memory handshake.
    lsu_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .op          (op),
        .split       (split),
        .lo_line     (lo_line),
        .hi_line     (hi_line),
        .dest        (dest),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .mem_tx_ra   (mem_tx_ra),
        .mem_rx_rp   (mem_rx_rp),
        .mem_rx_addr (mem_rx_addr),
        .mem_tx_rp   (mem_tx_rp),
        .mem_tx_wr   (mem_tx_wr),
        .mem_tx_addr (mem_tx_addr),
        .mem_tx_wmsk (mem_tx_wmsk),
        .mem_tx_data (mem_tx_data),
        .mem_rx_ra   (mem_rx_ra),
        .hi_piece    (hi_piece),
        .lo_take     (lo_take),
        .final_take  (final_take),
        .dn          (dn),
        .gpr_we      (gpr_we)
    );

endmodule

/* design/lsu_ctrl.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  lsu_op_e               op,
    input  logic                  split,
    input  addr_t                 lo_line,
    input  addr_t                 hi_line,
    input  gpr_idx_t              dest,
    input  line_t                 wr_data,
    input  mask_t                 wr_mask,
    input  logic                  mem_tx_ra,
    input  logic                  mem_rx_rp,
    input  addr_t                 mem_rx_addr,
    output logic                  mem_tx_rp,
    output logic                  mem_tx_wr,
    output addr_t                 mem_tx_addr,
    output mask_t                 mem_tx_wmsk,
    output line_t                 mem_tx_data,
    output logic                  mem_rx_ra,
    output logic                  hi_piece,
    output logic                  lo_take,
    output logic                  final_take,
    output logic                  dn,
    output logic [`LSU_GPR_N-1:0] gpr_we
);

    lsu_state_e state;
    logic       is_store;
    logic       rx_sample;
    logic       lo_match;
    logic       hi_match;
    logic       load_lo;
    logic       load_hi;

    assign is_store = (op == op_store_imm) || (op == op_store_reg);

    // A reply is sampled once; the ack cycle masks the held copy.
    assign rx_sample = mem_rx_rp && !mem_rx_ra;
    assign lo_match  = rx_sample && (state == st_wait_lo) && (mem_rx_addr == lo_line);
    assign hi_match  = rx_sample && (state == st_wait_hi) && (mem_rx_addr == hi_line);

    // Packer builds the upper piece while in the hi request state.
    assign hi_piece = (state == st_req_hi);

    // Field load points for the lower and upper request.
    assign load_lo = en && (state == st_idle);
    assign load_hi = en && hi_piece && !mem_tx_rp;

    // Strobes to the load aligner.
    assign lo_take    = lo_match && split;
    assign final_take = (lo_match && !split) || hi_match;

    // Request fields.
    // Loads send an empty mask and zero data.
    always_ff @(posedge clk) begin
        if (load_lo || load_hi) begin
            mem_tx_addr <= hi_piece ? hi_line : lo_line;
            mem_tx_wr   <= is_store;
            mem_tx_wmsk <= is_store ? wr_mask : '0;
            mem_tx_data <= is_store ? wr_data : '0;
        end
    end

    // Transfer sequencer.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            mem_tx_rp <= 1'b0;
            mem_rx_ra <= 1'b0;
            dn        <= 1'b0;
            gpr_we    <= '0;
        end else begin
            // Pulses default low.
            mem_rx_ra <= 1'b0;
            dn        <= 1'b0;
            gpr_we    <= '0;
            if (!en) begin
                state     <= st_idle;
                mem_tx_rp <= 1'b0;
            end else begin
                // Ack every reply seen while waiting, matching or not.
                if (rx_sample && (state == st_wait_lo || state == st_wait_hi)) begin
                    mem_rx_ra <= 1'b1;
                end
                // Register write goes out with done.
                if (final_take) begin
                    dn           <= 1'b1;
                    gpr_we[dest] <= 1'b1;
                end
                case (state)
                    st_idle: begin
                        mem_tx_rp <= 1'b1;
                        state     <= st_req_lo;
                    end
                    st_req_lo: begin
                        if (mem_tx_ra) begin
                            mem_tx_rp <= 1'b0;
                            if (!is_store) begin
                                state <= st_wait_lo;
                            end else if (split) begin
                                state <= st_req_hi;
                            end else begin
                                state <= st_done;
                                dn    <= 1'b1;
                            end
                        end
                    end
                    st_wait_lo: begin
                        // Wrong line keeps us here.
                        if (lo_match) begin
                            state <= split ? st_req_hi : st_done;
                        end
                    end
                    st_req_hi: begin
                        // One idle cycle on the bus, then the upper request.
                        if (!mem_tx_rp) begin
                            mem_tx_rp <= 1'b1;
                        end else if (mem_tx_ra) begin
                            mem_tx_rp <= 1'b0;
                            if (is_store) begin
                                state <= st_done;
                                dn    <= 1'b1;
                            end else begin
                                state <= st_wait_hi;
                            end
                        end
                    end
                    st_wait_hi: begin
                        if (hi_match) begin
                            state <= st_done;
                        end
                    end
                    st_done: begin
                        // Hold until the issuer drops en.
                        state <= st_done;
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // Pending request keeps its fields until accepted.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        en && mem_tx_rp && !mem_tx_ra |=> mem_tx_rp && $stable(mem_tx_addr) &&
        $stable(mem_tx_wr) && $stable(mem_tx_wmsk) && $stable(mem_tx_data))
        else $error("request fields changed before acceptance");

    // At most one register written, and only with done.
    a_we_dn: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gpr_we) && (!(|gpr_we) || dn))
        else $error("register write not one-hot or without done");

    // Done is a single pulse.
    a_dn_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dn |=> !dn)
        else $error("done held for two cycles");

endmodule

/* design/lsu_load_align.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  line_t rx_data,
    input  off_t  offset,
    input  logic  split,
    input  logic  lo_take,
    input  logic  final_take,
    output word_t load_word
);

    // Line position width with one carry bit.
    localparam int POS_W = `LSU_OFF_W + 1;

    // Reply bytes at offset + k, in word order.
    word_t                       lane_word;
    // Set where offset + k runs past the end of the line.
    logic [`LSU_WORD_BYTES-1:0]  carry;
    // Lower line bytes kept for a split load.
    word_t                       lo_hold;
    word_t                       word_next;

    // Byte k of the word sits at line position offset + k.
    always_comb begin
        logic [POS_W-1:0] pos;
        for (int k = 0; k < `LSU_WORD_BYTES; k++) begin
            pos = {1'b0, offset} + POS_W'(k);
            lane_word[k*8 +: 8] = rx_data[pos[`LSU_OFF_W-1:0]*8 +: 8];
            carry[k] = pos[POS_W-1];
        end
    end

    // Keep the lower line bytes.
    // Wrapped lanes are captured too but never selected.
    always_ff @(posedge clk) begin
        if (lo_take) begin
            lo_hold <= lane_word;
        end
    end

    // Split load takes non-wrapped bytes from the held lower line.
    // Wrapped bytes come from the upper line at the wrapped position.
    always_comb begin
        for (int k = 0; k < `LSU_WORD_BYTES; k++) begin
            if (split && !carry[k]) begin
                word_next[k*8 +: 8] = lo_hold[k*8 +: 8];
            end else begin
                word_next[k*8 +: 8] = lane_word[k*8 +: 8];
            end
        end
    end

    // Final word, valid the cycle after final_take.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_word <= '0;
        end else if (final_take) begin
            load_word <= word_next;
        end
    end

endmodule

/* design/lsu_operand_sel.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_operand_sel
    import lsu_pkg::*;
(
    input  lsu_op_e  op,
    input  addr_t    imm,
    input  gpr_idx_t reg_a,
    input  gpr_idx_t reg_b,
    input  word_t    gpr_rdata [`LSU_GPR_N],
    output addr_t    lo_line,
    output addr_t    hi_line,
    output off_t     offset,
    output logic     split,
    output gpr_idx_t dest,
    output word_t    store_word
);

    // Byte address of the first and last byte of the word.
    addr_t addr;
    addr_t last_byte;

    // Operand roles per opcode.
    always_comb begin
        addr = imm;
        dest = reg_a;
        case (op)
            op_load_imm: begin
                addr = imm;
                dest = reg_a;
            end
            op_load_reg: begin
                // Address from register A, result into register B.
                addr = gpr_rdata[reg_a];
                dest = reg_b;
            end
            op_store_imm: begin
                addr = imm;
            end
            op_store_reg: begin
                // Address from register B.
                addr = gpr_rdata[reg_b];
            end
            default: begin
                addr = imm;
            end
        endcase
    end

    // Store data always comes from register A.
    assign store_word = gpr_rdata[reg_a];

    // Last byte may wrap past the top of the address space.
    assign last_byte = addr + addr_t'(`LSU_WORD_BYTES - 1);

    // Line addresses have the offset bits cleared.
    assign lo_line = addr & ~addr_t'(`LSU_LINE_BYTES - 1);
    assign hi_line = last_byte & ~addr_t'(`LSU_LINE_BYTES - 1);
    assign offset  = addr[`LSU_OFF_W-1:0];

    // Word crosses a line boundary.
    assign split = (lo_line != hi_line);

endmodule

/* design/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Byte address width.
`define LSU_ADDR_W 32

// Bytes in one register word.
`define LSU_WORD_BYTES 4

// Bytes in one memory line.
`define LSU_LINE_BYTES 16

// Line width in bits.
`define LSU_LINE_W 128

// Byte offset width within a line.
`define LSU_OFF_W 4

// Register file size and index width.
`define LSU_GPR_N 16
`define LSU_GPR_IDX_W 4

`endif

/* design/lsu_pkg.sv */
`include "lsu_params.svh"

package lsu_pkg;

    // Opcodes keep their original 5-bit encodings.
    typedef enum logic [4:0] {
        op_load_imm  = 5'b00000,
        op_load_reg  = 5'b11001,
        op_store_imm = 5'b10000,
        op_store_reg = 5'b01001
    } lsu_op_e;

    // Sequencer states.
    typedef enum logic [2:0] {
        st_idle,
        st_req_lo,
        st_wait_lo,
        st_req_hi,
        st_wait_hi,
        st_done
    } lsu_state_e;

    // Data and address types.
    typedef logic [`LSU_WORD_BYTES*8-1:0] word_t;
    typedef logic [`LSU_ADDR_W-1:0]       addr_t;
    typedef logic [`LSU_LINE_W-1:0]       line_t;
    typedef logic [`LSU_LINE_BYTES-1:0]   mask_t;
    typedef logic [`LSU_GPR_IDX_W-1:0]    gpr_idx_t;
    typedef logic [`LSU_OFF_W-1:0]        off_t;

endpackage

/* design/lsu_store_pack.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_store_pack
    import lsu_pkg::*;
(
    input  word_t store_word,
    input  off_t  offset,
    input  logic  split,
    input  logic  hi_piece,
    output line_t wr_data,
    output mask_t wr_mask
);

    // Bits needed to pick a byte out of the word.
    localparam int SEL_W = $clog2(`LSU_WORD_BYTES);

    // Upper line piece only exists for a split store.
    logic hi_sel;

    assign hi_sel = split && hi_piece;

    // For each line byte, find which word byte lands there.
    // Lower piece uses k = i - offset.
    // Upper piece sits one line further on, so k = i + 16 - offset.
    // A negative k wraps to a large value and fails the range check.
    always_comb begin
        logic [`LSU_OFF_W:0] k;
        wr_data = '0;
        wr_mask = '0;
        for (int i = 0; i < `LSU_LINE_BYTES; i++) begin
            k = {hi_sel, off_t'(i)} - {1'b0, offset};
            if (k < `LSU_WORD_BYTES) begin
                wr_mask[i]       = 1'b1;
                wr_data[i*8 +: 8] = store_word[k[SEL_W-1:0]*8 +: 8];
            end
        end
    end

endmodule

/* dv/lsu_cases.txt */
// op imm reg_a reg_b value_a value_b expected_load_word (all hex)
// op: 00 load imm, 19 load reg, 10 store imm, 09 store reg; expected is 0 for stores
00 00000100 1 2 00000000 00000000 18110A03
19 00000000 3 5 00000204 00000000 342D261F
00 0000010E 2 0 00000000 00000000 7A736C65
10 00000400 1 0 A1B2C3D4 00000000 00000000
00 00000400 3 0 00000000 00000000 A1B2C3D4
09 00000000 2 6 11223344 0000050F 00000000
19 00000000 8 9 0000050F 00000000 11223344
00 0000033D 4 0 00000000 00000000 C3BCB5AE
10 0000060D 3 0 DEADBEEF 00000000 00000000
19 00000000 A B 0000060E 00000000 7ADEADBE
09 00000000 C D CAFEF00D 00000708 00000000
00 00000706 E 0 00000000 00000000 F00D342D
10 000007FE F 0 55667788 00000000 00000000
19 00000000 0 1 000007FD 00000000 667788EE
00 0000080C 6 0 00000000 00000000 6C655E57
00 0000070A 5 0 00000000 00000000 5E57CAFE

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int MAX_CASES = 32;
    localparam int FIELDS    = 7;
    localparam int TIMEOUT   = 200;
    localparam int MEM_BYTES = 4096;

    logic                  clk;
    logic                  rst_n;
    logic                  en;
    lsu_op_e               op;
    addr_t                 imm;
    gpr_idx_t              reg_a;
    gpr_idx_t              reg_b;
    word_t                 gpr_rdata [`LSU_GPR_N];
    logic                  dn;
    logic [`LSU_GPR_N-1:0] gpr_we;
    word_t                 gpr_wdata;
    logic                  mem_tx_rp;
    addr_t                 mem_tx_addr;
    logic                  mem_tx_wr;
    mask_t                 mem_tx_wmsk;
    line_t                 mem_tx_data;
    logic                  mem_tx_ra;
    logic                  mem_rx_rp;
    addr_t                 mem_rx_addr;
    line_t                 mem_rx_data;
    logic                  mem_rx_ra;

    // Seven hex words per case in the order op, imm, reg_a, reg_b, value a, value b, expected.
    word_t       cases [MAX_CASES*FIELDS];
    // Byte memory that wraps at 4 KiB.
    logic [7:0]  mem [MEM_BYTES];
    logic [15:0] lfsr;
    int          errors;
    // Low until the last transfer of a case has been handed over.
    logic        dn_allowed;

    load_store_unit i_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        // Galois form with taps 16 14 13 11.
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Delay of 0 to 3 cycles with one LFSR step per bit.
    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = (d << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp)
            report_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                   $time, what, got, exp));
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp)
            report_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                   $time, what, got, exp));
    endtask

    task automatic check_line(line_t got, line_t exp, string what);
        if (got !== exp)
            report_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                   $time, what, got, exp));
    endtask

    task automatic check_mask(mask_t got, mask_t exp, string what);
        if (got !== exp)
            report_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                   $time, what, got, exp));
    endtask

    task automatic check_idx(gpr_idx_t got, gpr_idx_t exp, string what);
        if (got !== exp)
            report_error($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                                   $time, what, got, exp));
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
            report_error($sformatf("FAILED at %0t: %s is %b, expected %b",
                                   $time, what, got, exp));
    endtask

    // Step to the next falling edge and flag any early write.
    task automatic tick();
        @(negedge clk);
        if (!dn_allowed && (dn !== 1'b0 || gpr_we !== '0))
            report_error($sformatf("FAILED at %0t: dn or gpr_we raised too early", $time));
    endtask

    task automatic check_idle_outputs(string when);
        check_bit(mem_tx_rp, 1'b0, {"mem_tx_rp ", when});
        check_bit(mem_rx_ra, 1'b0, {"mem_rx_ra ", when});
        check_bit(dn, 1'b0, {"dn ", when});
        check_mask(gpr_we, '0, {"gpr_we ", when});
    endtask

    function automatic line_t build_line(addr_t line);
        line_t l;
        for (int i = 0; i < `LSU_LINE_BYTES; i++) begin
            l[i*8 +: 8] = mem[(line + i) % MEM_BYTES];
        end
        return l;
    endfunction

    // Word byte k goes to address addr + k if that byte falls in this line.
    task automatic expect_store(input addr_t addr, input word_t data, input addr_t line,
                                output line_t exp_data, output mask_t exp_mask);
        addr_t b;
        exp_data = '0;
        exp_mask = '0;
        for (int k = 0; k < `LSU_WORD_BYTES; k++) begin
            b = addr + k;
            if ((b & ~addr_t'(`LSU_LINE_BYTES - 1)) == line) begin
                exp_mask[b[3:0]]        = 1'b1;
                exp_data[b[3:0]*8 +: 8] = data[k*8 +: 8];
            end
        end
    endtask

    task automatic serve_request(input addr_t line, input logic is_store, input addr_t addr,
                                 input word_t data, input logic last);
        int    d;
        int    cnt;
        line_t exp_data;
        mask_t exp_mask;
        cnt = 0;
        while (mem_tx_rp !== 1'b1) begin
            tick();
            cnt++;
            if (cnt > TIMEOUT)
                report_error("Timeout: the unit raised no memory request within 200 cycles");
        end
        check_addr(mem_tx_addr, line, "request line address");
        check_bit(mem_tx_wr, is_store, "request write flag");
        expect_store(addr, data, line, exp_data, exp_mask);
        if (is_store) begin
            check_mask(mem_tx_wmsk, exp_mask, "store byte mask");
            check_line(mem_tx_data, exp_data, "store line data");
        end
        // Hold off acceptance and watch the fields.
        draw_delay(d);
        for (int i = 0; i < d; i++) begin
            tick();
            check_bit(mem_tx_rp, 1'b1, "request under back-pressure");
            check_addr(mem_tx_addr, line, "held request address");
            if (is_store) begin
                check_mask(mem_tx_wmsk, exp_mask, "held store mask");
                check_line(mem_tx_data, exp_data, "held store data");
            end
        end
        mem_tx_ra = 1'b1;
        if (is_store) begin
            for (int i = 0; i < `LSU_LINE_BYTES; i++) begin
                if (mem_tx_wmsk[i]) mem[(line + i) % MEM_BYTES] = mem_tx_data[i*8 +: 8];
            end
        end
        dn_allowed = last;
        tick();
        mem_tx_ra = 1'b0;
        check_bit(mem_tx_rp, 1'b0, "request after acceptance");
    endtask

    task automatic wait_rx_ack(string what);
        int cnt;
        cnt = 0;
        while (mem_rx_ra !== 1'b1) begin
            tick();
            cnt++;
            if (cnt > TIMEOUT)
                report_error({"Timeout: the unit did not acknowledge the ", what});
        end
        mem_rx_rp = 1'b0;
    endtask

    task automatic serve_reply(input addr_t line, input logic inject, input logic last);
        int d;
        draw_delay(d);
        repeat (d) tick();
        if (inject) begin
            // Reply for another line comes first.
            mem_rx_rp   = 1'b1;
            mem_rx_addr = line ^ 32'h40;
            mem_rx_data = ~build_line(line);
            wait_rx_ack("wrong-address reply");
            tick();
        end
        mem_rx_rp   = 1'b1;
        mem_rx_addr = line;
        mem_rx_data = build_line(line);
        dn_allowed  = last;
        wait_rx_ack("read reply");
    endtask

    task automatic run_case(input int idx);
        lsu_op_e  c_op;
        word_t    val_a;
        word_t    val_b;
        addr_t    addr;
        addr_t    lo;
        addr_t    hi;
        gpr_idx_t dest;
        gpr_idx_t got_idx;
        logic     is_store;
        logic     split;
        int       cnt;
        c_op  = lsu_op_e'(cases[idx*FIELDS][4:0]);
        imm   = cases[idx*FIELDS+1];
        reg_a = gpr_idx_t'(cases[idx*FIELDS+2]);
        reg_b = gpr_idx_t'(cases[idx*FIELDS+3]);
        val_a = cases[idx*FIELDS+4];
        val_b = cases[idx*FIELDS+5];
        // Operand roles by opcode.
        is_store = (c_op == op_store_imm) || (c_op == op_store_reg);
        addr     = (c_op == op_load_reg) ? val_a : (c_op == op_store_reg) ? val_b : imm;
        dest     = (c_op == op_load_reg) ? reg_b : reg_a;
        lo       = addr & ~addr_t'(`LSU_LINE_BYTES - 1);
        hi       = (addr + 3) & ~addr_t'(`LSU_LINE_BYTES - 1);
        split    = (lo != hi);
        for (int i = 0; i < `LSU_GPR_N; i++) gpr_rdata[i] = 32'h5A00_0000 + i;
        gpr_rdata[reg_b] = val_b;
        gpr_rdata[reg_a] = val_a;
        op         = c_op;
        dn_allowed = 1'b0;
        en         = 1'b1;
        serve_request(lo, is_store, addr, val_a, is_store && !split);
        if (!is_store) serve_reply(lo, (idx % 3) == 1, !split);
        if (split) begin
            serve_request(hi, is_store, addr, val_a, is_store);
            if (!is_store) serve_reply(hi, 1'b0, 1'b1);
        end
        cnt = 0;
        while (dn !== 1'b1) begin
            tick();
            cnt++;
            if (cnt > TIMEOUT) report_error("Timeout: the unit never signalled done");
        end
        if (is_store) begin
            check_mask(gpr_we, '0, "gpr_we on a store");
        end else begin
            check_word(gpr_wdata, cases[idx*FIELDS+6], "load result");
            // Index of the highest enable bit, then the full one-hot pattern.
            got_idx = '0;
            for (int i = 0; i < `LSU_GPR_N; i++) begin
                if (gpr_we[i]) begin
                    got_idx = gpr_idx_t'(i);
                end
            end
            check_idx(got_idx, dest, "written register");
            check_mask(gpr_we, mask_t'(1) << dest, "gpr_we");
        end
        // Issuer drops en the cycle after done.
        en         = 1'b0;
        dn_allowed = 1'b0;
        tick();
    endtask

    initial begin
        int n;
        errors      = 0;
        lfsr        = 16'd96;
        dn_allowed  = 1'b0;
        rst_n       = 1'b0;
        en          = 1'b0;
        op          = op_load_imm;
        imm         = '0;
        reg_a       = '0;
        reg_b       = '0;
        mem_tx_ra   = 1'b0;
        mem_rx_rp   = 1'b0;
        mem_rx_addr = '0;
        mem_rx_data = '0;
        for (int i = 0; i < `LSU_GPR_N; i++) gpr_rdata[i] = '0;
        // Byte at address a holds the low byte of a * 7 + 3.
        for (int a = 0; a < MEM_BYTES; a++) mem[a] = 8'(a * 7 + 3);
        for (int i = 0; i < MAX_CASES*FIELDS; i++) cases[i] = '1;
        $readmemh("dv/lsu_cases.txt", cases);
        repeat (4) begin
            tick();
            check_idle_outputs("during reset");
        end
        rst_n = 1'b1;
        tick();
        check_idle_outputs("after reset");
        n = 0;
        while (n < MAX_CASES && cases[n*FIELDS] !== '1) begin
            run_case(n);
            n++;
        end
        if (n == 0) report_error("No cases were read from dv/lsu_cases.txt");
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
